// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // rt field selects the regimm branch
    localparam logic [reg_addr_w-1:0] rt_bltz   = 5'h00;
    localparam logic [reg_addr_w-1:0] rt_bgez   = 5'h01;
    localparam logic [reg_addr_w-1:0] rt_bltzal = 5'h10;
    localparam logic [reg_addr_w-1:0] rt_bgezal = 5'h11;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] sa;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm16;
    } i_fields_t;

    // same word, two field layouts
    typedef union packed {
        r_fields_t         r;
        i_fields_t         i;
        logic [data_w-1:0] raw;
    } inst_u;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // one-hot alu op, add sits in the top bit
    localparam int alu_op_w = 12;
    localparam int alu_add  = 11;
    localparam int alu_sub  = 10;
    localparam int alu_slt  = 9;
    localparam int alu_sltu = 8;
    localparam int alu_and  = 7;
    localparam int alu_nor  = 6;
    localparam int alu_or   = 5;
    localparam int alu_xor  = 4;
    localparam int alu_sll  = 3;
    localparam int alu_srl  = 2;
    localparam int alu_sra  = 1;
    localparam int alu_lui  = 0;

    // operand selector bits
    localparam int src1_w     = 3;
    localparam int src1_rs    = 0;
    localparam int src1_pc    = 1;
    localparam int src1_sa    = 2;
    localparam int src2_w     = 4;
    localparam int src2_rt    = 0;
    localparam int src2_simm  = 1;
    localparam int src2_eight = 2;
    localparam int src2_zimm  = 3;

    // branch kinds, one bit each
    localparam int br_kind_w       = 8;
    localparam int br_eq           = 0;
    localparam int br_ne           = 1;
    localparam int br_ge           = 2;
    localparam int br_gt           = 3;
    localparam int br_le           = 4;
    localparam int br_lt           = 5;
    localparam int br_always_imm26 = 6;
    localparam int br_always_reg   = 7;

    typedef logic [br_kind_w-1:0] br_kind_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] pc;
        inst_u             inst;
    } fetch_t;

    typedef struct packed {
        logic fetch;
        logic decode;
    } stall_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [data_w-1:0]     wdata;
    } rf_write_t;

    typedef struct packed {
        logic                  we;
        logic                  is_load;
        logic [reg_addr_w-1:0] waddr;
        logic [data_w-1:0]     wdata;
    } fwd_t;

    typedef struct packed {
        logic [alu_op_w-1:0]   alu_op;
        logic [src1_w-1:0]     src1_sel;
        logic [src2_w-1:0]     src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
    } decode_ctrl_t;

    typedef struct packed {
        logic [data_w-1:0] pc;
        inst_u             inst;
        decode_ctrl_t      ctrl;
        logic [data_w-1:0] rs_value;
        logic [data_w-1:0] rt_value;
    } id_to_ex_t;

    typedef struct packed {
        logic              taken;
        logic [data_w-1:0] target;
    } br_t;

endpackage

`default_nettype wire

// File: decode/branch_unit.sv
`default_nettype none

module branch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic [data_w-1:0] pc,
    input  inst_u             inst,
    input  br_kind_t          br_kind,
    input  logic [data_w-1:0] rs_value,
    input  logic [data_w-1:0] rt_value,
    output br_t               br
);

    logic [data_w-1:0] pc_plus4;
    logic [data_w-1:0] br_offset;
    logic [data_w-1:0] jump_target;
    logic              rs_eq_rt;
    logic              rs_neg;
    logic              rs_zero;

    assign pc_plus4    = pc + data_w'(4);
    assign br_offset   = {{(data_w-18){inst.i.imm16[15]}}, inst.i.imm16, 2'b00};
    // region of the delay slot, not of the jump itself
    assign jump_target = {pc_plus4[data_w-1:data_w-4], inst.raw[25:0], 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[data_w-1];
    assign rs_zero  = (rs_value == '0);

    assign br.taken = (br_kind[br_eq] & rs_eq_rt)
                    | (br_kind[br_ne] & ~rs_eq_rt)
                    | (br_kind[br_ge] & ~rs_neg)
                    | (br_kind[br_gt] & ~rs_neg & ~rs_zero)
                    | (br_kind[br_le] & (rs_neg | rs_zero))
                    | (br_kind[br_lt] & rs_neg)
                    | br_kind[br_always_imm26]
                    | br_kind[br_always_reg];

    always_comb begin
        if (br_kind[br_always_reg]) begin
            br.target = rs_value;
        end else if (br_kind[br_always_imm26]) begin
            br.target = jump_target;
        end else if (|br_kind) begin
            br.target = pc_plus4 + br_offset;
        end else begin
            br.target = '0;
        end
    end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  stall_t    stall,
    input  fetch_t    fetch,
    input  rf_write_t wb_write,
    input  fwd_t      ex_fwd,
    input  fwd_t      mem_fwd,
    output id_to_ex_t id_to_ex,
    output br_t       br,
    output logic      stall_req
);

    fetch_t            fetch_q;
    decode_ctrl_t      ctrl;
    br_kind_t          br_kind;
    logic [data_w-1:0] rs_value;
    logic [data_w-1:0] rt_value;

    // fetch stalled alone: bubble, both stalled: hold
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q <= '0;
        end else if (stall.fetch && !stall.decode) begin
            fetch_q <= '0;
        end else if (!stall.fetch) begin
            fetch_q <= fetch;
        end
    end

    inst_decoder inst_decoder_i (
        .inst    (fetch_q.inst),
        .valid   (fetch_q.valid),
        .ctrl    (ctrl),
        .br_kind (br_kind)
    );

    operand_fetch operand_fetch_i (
        .clk      (clk),
        .rs_addr  (fetch_q.inst.i.rs),
        .rt_addr  (fetch_q.inst.i.rt),
        .wb_write (wb_write),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .rs_value (rs_value),
        .rt_value (rt_value)
    );

    branch_unit branch_unit_i (
        .pc       (fetch_q.pc),
        .inst     (fetch_q.inst),
        .br_kind  (br_kind),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    // load in execute feeds a source of this instruction
    assign stall_req = fetch_q.valid && ex_fwd.we && ex_fwd.is_load
                       && (ex_fwd.waddr != '0)
                       && ((ex_fwd.waddr == fetch_q.inst.i.rs)
                           || (ex_fwd.waddr == fetch_q.inst.i.rt));

    assign id_to_ex.pc       = fetch_q.pc;
    assign id_to_ex.inst     = fetch_q.inst;
    assign id_to_ex.ctrl     = ctrl;
    assign id_to_ex.rs_value = rs_value;
    assign id_to_ex.rt_value = rt_value;

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`default_nettype none

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_u        inst,
    input  logic         valid,
    output decode_ctrl_t ctrl,
    output br_kind_t     br_kind
);

    logic fields_ok;

    function automatic decode_ctrl_t alu_ctrl(
        input int                    alu_bit,
        input int                    s1_bit,
        input int                    s2_bit,
        input logic                  we,
        input logic [reg_addr_w-1:0] waddr
    );
        decode_ctrl_t c;
        c = '0;
        c.alu_op[alu_bit] = 1'b1;
        c.src1_sel[s1_bit] = 1'b1;
        c.src2_sel[s2_bit] = 1'b1;
        c.rf_we = we;
        c.rf_waddr = waddr;
        return c;
    endfunction

    // reserved fields that must read zero
    always_comb begin
        case (inst.i.opcode)
            op_special: begin
                case (inst.r.funct)
                    fn_sll, fn_srl, fn_sra: fields_ok = (inst.r.rs == '0);
                    fn_jr: begin
                        fields_ok = (inst.r.rt == '0) && (inst.r.rd == '0) && (inst.r.sa == '0);
                    end
                    fn_jalr: fields_ok = (inst.r.rt == '0) && (inst.r.sa == '0);
                    default: fields_ok = (inst.r.sa == '0);
                endcase
            end
            op_blez, op_bgtz: fields_ok = (inst.i.rt == '0);
            default: fields_ok = 1'b1;
        endcase
    end

    always_comb begin
        ctrl = '0;
        br_kind = '0;
        if (valid && fields_ok) begin
            case (inst.i.opcode)
                op_special: begin
                    case (inst.r.funct)
                        fn_addu: ctrl = alu_ctrl(alu_add, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_subu: ctrl = alu_ctrl(alu_sub, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_and:  ctrl = alu_ctrl(alu_and, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_or:   ctrl = alu_ctrl(alu_or, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_xor:  ctrl = alu_ctrl(alu_xor, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_nor:  ctrl = alu_ctrl(alu_nor, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_slt:  ctrl = alu_ctrl(alu_slt, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_sltu: ctrl = alu_ctrl(alu_sltu, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        // shift amount from sa
                        fn_sll:  ctrl = alu_ctrl(alu_sll, src1_sa, src2_rt, 1'b1, inst.r.rd);
                        fn_srl:  ctrl = alu_ctrl(alu_srl, src1_sa, src2_rt, 1'b1, inst.r.rd);
                        fn_sra:  ctrl = alu_ctrl(alu_sra, src1_sa, src2_rt, 1'b1, inst.r.rd);
                        // shift amount from rs
                        fn_sllv: ctrl = alu_ctrl(alu_sll, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_srlv: ctrl = alu_ctrl(alu_srl, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_srav: ctrl = alu_ctrl(alu_sra, src1_rs, src2_rt, 1'b1, inst.r.rd);
                        fn_jr:   br_kind[br_always_reg] = 1'b1;
                        fn_jalr: begin
                            ctrl = alu_ctrl(alu_add, src1_pc, src2_eight, 1'b1, inst.r.rd);
                            br_kind[br_always_reg] = 1'b1;
                        end
                        default: ;
                    endcase
                end
                op_regimm: begin
                    case (inst.i.rt)
                        rt_bltz: br_kind[br_lt] = 1'b1;
                        rt_bgez: br_kind[br_ge] = 1'b1;
                        rt_bltzal: begin
                            ctrl = alu_ctrl(alu_add, src1_pc, src2_eight, 1'b1, link_reg);
                            br_kind[br_lt] = 1'b1;
                        end
                        rt_bgezal: begin
                            ctrl = alu_ctrl(alu_add, src1_pc, src2_eight, 1'b1, link_reg);
                            br_kind[br_ge] = 1'b1;
                        end
                        default: ;
                    endcase
                end
                op_j:    br_kind[br_always_imm26] = 1'b1;
                op_jal: begin
                    // link value is pc + 8
                    ctrl = alu_ctrl(alu_add, src1_pc, src2_eight, 1'b1, link_reg);
                    br_kind[br_always_imm26] = 1'b1;
                end
                op_beq:   br_kind[br_eq] = 1'b1;
                op_bne:   br_kind[br_ne] = 1'b1;
                op_blez:  br_kind[br_le] = 1'b1;
                op_bgtz:  br_kind[br_gt] = 1'b1;
                op_addiu: ctrl = alu_ctrl(alu_add, src1_rs, src2_simm, 1'b1, inst.i.rt);
                op_slti:  ctrl = alu_ctrl(alu_slt, src1_rs, src2_simm, 1'b1, inst.i.rt);
                op_sltiu: ctrl = alu_ctrl(alu_sltu, src1_rs, src2_simm, 1'b1, inst.i.rt);
                op_andi:  ctrl = alu_ctrl(alu_and, src1_rs, src2_zimm, 1'b1, inst.i.rt);
                op_ori:   ctrl = alu_ctrl(alu_or, src1_rs, src2_zimm, 1'b1, inst.i.rt);
                op_xori:  ctrl = alu_ctrl(alu_xor, src1_rs, src2_zimm, 1'b1, inst.i.rt);
                op_lui: begin
                    // lui takes only the immediate
                    ctrl = alu_ctrl(alu_lui, src1_rs, src2_simm, 1'b1, inst.i.rt);
                    ctrl.src1_sel = '0;
                end
                op_lw: begin
                    ctrl = alu_ctrl(alu_add, src1_rs, src2_simm, 1'b1, inst.i.rt);
                    ctrl.mem_en = 1'b1;
                end
                op_sw: begin
                    ctrl = alu_ctrl(alu_add, src1_rs, src2_simm, 1'b0, '0);
                    ctrl.mem_en = 1'b1;
                    ctrl.mem_we = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: decode/operand_fetch.sv
`default_nettype none

module operand_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] rs_addr,
    input  logic [reg_addr_w-1:0] rt_addr,
    input  rf_write_t             wb_write,
    input  fwd_t                  ex_fwd,
    input  fwd_t                  mem_fwd,
    output logic [data_w-1:0]     rs_value,
    output logic [data_w-1:0]     rt_value
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    // youngest producer wins: ex, then mem, then write-back
    function automatic logic [data_w-1:0] pick_operand(
        input logic [reg_addr_w-1:0] addr,
        input logic [data_w-1:0]     stored,
        input fwd_t                  ex,
        input fwd_t                  mem,
        input rf_write_t             wb
    );
        logic [data_w-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex.we && (ex.waddr == addr)) begin
            value = ex.wdata;
        end else if (mem.we && (mem.waddr == addr)) begin
            value = mem.wdata;
        end else if (wb.we && (wb.waddr == addr)) begin
            value = wb.wdata;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb_write.we && (wb_write.waddr != '0)) begin
            regs[wb_write.waddr] <= wb_write.wdata;
        end
    end

    assign rs_value = pick_operand(rs_addr, regs[rs_addr], ex_fwd, mem_fwd, wb_write);
    assign rt_value = pick_operand(rt_addr, regs[rt_addr], ex_fwd, mem_fwd, wb_write);

endmodule

`default_nettype wire

// File: src.f
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
decode/inst_decoder.sv
decode/operand_fetch.sv
decode/branch_unit.sv
decode/decode_stage.sv
testbench/tb_decode_stage.sv

// File: testbench/decode_ref.svh
`ifndef decode_ref_svh
`define decode_ref_svh

// reserved fields of the kept encodings that must be zero
function automatic logic reserved_ok(input logic [31:0] w);
    logic [5:0] op;
    logic [5:0] fn;
    op = w[31:26];
    fn = w[5:0];
    if (op == op_special) begin
        if (fn == fn_sll || fn == fn_srl || fn == fn_sra) return w[25:21] == 5'd0;
        if (fn == fn_jr) return w[20:6] == 15'd0;
        if (fn == fn_jalr) return (w[20:16] == 5'd0) && (w[10:6] == 5'd0);
        return w[10:6] == 5'd0;
    end
    if (op == op_blez || op == op_bgtz) return w[20:16] == 5'd0;
    return 1'b1;
endfunction

function automatic decode_ctrl_t ref_ctrl(input logic valid, input logic [31:0] w);
    decode_ctrl_t c;
    logic [5:0]   op;
    logic [5:0]   fn;
    logic         link;
    int           alu;
    int           s1;
    int           s2;
    op = w[31:26];
    fn = w[5:0];
    c = '0;
    c.rf_we = 1'b1;
    c.rf_waddr = w[20:16];
    link = 1'b0;
    alu = -1;
    s1 = src1_rs;
    s2 = src2_simm;
    case (op)
        op_special: begin
            c.rf_waddr = w[15:11];
            s2 = src2_rt;
            case (fn)
                fn_addu: alu = alu_add;
                fn_subu: alu = alu_sub;
                fn_and:  alu = alu_and;
                fn_or:   alu = alu_or;
                fn_xor:  alu = alu_xor;
                fn_nor:  alu = alu_nor;
                fn_slt:  alu = alu_slt;
                fn_sltu: alu = alu_sltu;
                fn_sllv: alu = alu_sll;
                fn_srlv: alu = alu_srl;
                fn_srav: alu = alu_sra;
                fn_jalr: link = 1'b1;
                default: ;
            endcase
            // shift amount comes from sa
            if (fn == fn_sll || fn == fn_srl || fn == fn_sra) begin
                s1 = src1_sa;
                alu = (fn == fn_sll) ? alu_sll : (fn == fn_srl) ? alu_srl : alu_sra;
            end
        end
        op_regimm: link = (w[20:16] == rt_bltzal) || (w[20:16] == rt_bgezal);
        op_jal:    link = 1'b1;
        op_addiu:  alu = alu_add;
        op_slti:   alu = alu_slt;
        op_sltiu:  alu = alu_sltu;
        op_andi, op_ori, op_xori: begin
            s2 = src2_zimm;
            alu = (op == op_andi) ? alu_and : (op == op_ori) ? alu_or : alu_xor;
        end
        op_lui: begin
            alu = alu_lui;
            s1 = -1;
        end
        op_lw: begin
            alu = alu_add;
            c.mem_en = 1'b1;
        end
        op_sw: begin
            alu = alu_add;
            c.mem_en = 1'b1;
            c.mem_we = 1'b1;
            c.rf_we = 1'b0;
            c.rf_waddr = '0;
        end
        default: ;
    endcase
    // link value pc + 8, into rd for jalr and r31 otherwise
    if (link) begin
        alu = alu_add;
        s1 = src1_pc;
        s2 = src2_eight;
        if (op != op_special) c.rf_waddr = link_reg;
    end
    if (!valid || !reserved_ok(w) || alu < 0) return '0;
    c.alu_op[alu] = 1'b1;
    if (s1 >= 0) c.src1_sel[s1] = 1'b1;
    c.src2_sel[s2] = 1'b1;
    return c;
endfunction

function automatic br_t ref_branch(input logic valid, input logic [31:0] pc,
                                   input logic [31:0] w, input logic [31:0] rs_v,
                                   input logic [31:0] rt_v);
    br_t         b;
    logic [31:0] pc4;
    logic        cond;
    logic        is_cond;
    b = '0;
    pc4 = pc + 32'd4;
    cond = 1'b0;
    is_cond = 1'b0;
    if (!valid || !reserved_ok(w)) return b;
    case (w[31:26])
        op_special: begin
            if (w[5:0] == fn_jr || w[5:0] == fn_jalr) begin
                b.taken = 1'b1;
                b.target = rs_v;
            end
        end
        op_j, op_jal: begin
            b.taken = 1'b1;
            b.target = {pc4[31:28], w[25:0], 2'b00};
        end
        op_beq: begin
            is_cond = 1'b1;
            cond = (rs_v == rt_v);
        end
        op_bne: begin
            is_cond = 1'b1;
            cond = (rs_v != rt_v);
        end
        op_blez: begin
            is_cond = 1'b1;
            cond = ($signed(rs_v) <= 32'sd0);
        end
        op_bgtz: begin
            is_cond = 1'b1;
            cond = ($signed(rs_v) > 32'sd0);
        end
        op_regimm: begin
            is_cond = (w[20:16] == rt_bltz) || (w[20:16] == rt_bgez)
                      || (w[20:16] == rt_bltzal) || (w[20:16] == rt_bgezal);
            if (w[20:16] == rt_bgez || w[20:16] == rt_bgezal) begin
                cond = ($signed(rs_v) >= 32'sd0);
            end else begin
                cond = ($signed(rs_v) < 32'sd0);
            end
        end
        default: ;
    endcase
    if (is_cond) begin
        b.taken = cond;
        b.target = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
    end
    return b;
endfunction

// later sources override earlier ones
function automatic logic [31:0] ref_operand(input logic [4:0] addr, input fwd_t ex,
                                            input fwd_t mem, input rf_write_t wb);
    logic [31:0] v;
    v = shadow[addr];
    if (wb.we && wb.waddr == addr) v = wb.wdata;
    if (mem.we && mem.waddr == addr) v = mem.wdata;
    if (ex.we && ex.waddr == addr) v = ex.wdata;
    if (addr == 5'd0) v = '0;
    return v;
endfunction

function automatic logic ref_stall(input logic valid, input logic [31:0] w, input fwd_t ex);
    return valid && ex.we && ex.is_load && (ex.waddr != 5'd0)
           && (ex.waddr == w[25:21] || ex.waddr == w[20:16]);
endfunction

`endif

// File: testbench/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int n_fwd    = 200;
    localparam int n_dec    = 300;
    localparam int n_br     = 200;
    localparam int n_load   = 150;
    localparam int n_cycles = 4 + 66 + n_fwd + n_dec + n_br + n_load + 40;

    // index k sits at the low end
    localparam logic [16*6-1:0] fn_table = {fn_jalr, fn_jr, fn_srav, fn_srlv, fn_sllv, fn_sra,
        fn_srl, fn_sll, fn_sltu, fn_slt, fn_nor, fn_xor, fn_or, fn_and, fn_subu, fn_addu};
    localparam logic [4*5-1:0] rimm_table = {rt_bgezal, rt_bltzal, rt_bgez, rt_bltz};
    localparam logic [15*6-1:0] op_table = {op_sw, op_lw, op_lui, op_xori, op_ori, op_andi,
        op_sltiu, op_slti, op_addiu, op_bgtz, op_blez, op_bne, op_beq, op_jal, op_j};
    // dropped or malformed encodings
    localparam logic [9*32-1:0] unknown_words = {32'hfc000000, 32'h00000001, 32'h04050000,
        32'h00221861, 32'h00200808, 32'h20220004, 32'h80220004, 32'h00220018, 32'h18210004};

    logic        clk;
    logic        rst;
    stall_t      stall;
    fetch_t      fetch;
    rf_write_t   wb_write;
    fwd_t        ex_fwd;
    fwd_t        mem_fwd;
    id_to_ex_t   id_to_ex;
    br_t         br;
    logic        stall_req;
    logic [31:0] shadow [32];
    fetch_t      model_q;
    logic        check_on;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_base;

    `include "decode_ref.svh"

    decode_stage decode_stage_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetch     (fetch),
        .wb_write  (wb_write),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .id_to_ex  (id_to_ex),
        .br        (br),
        .stall_req (stall_req)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] edge_value();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return 32'h0;
            3'd1: return 32'h1;
            3'd2: return 32'hffffffff;
            3'd3: return 32'h80000000;
            3'd4: return 32'h7fffffff;
            default: return next_rand();
        endcase
    endfunction

    // sel 0..15 special, 16..19 regimm, 20..34 major opcodes
    function automatic logic [31:0] pick_inst(input int sel, input logic [31:0] f);
        logic [31:0] w;
        w = f;
        if (sel < 16) begin
            w[31:26] = op_special;
            w[5:0] = fn_table[sel*6 +: 6];
            if (w[5:0] == fn_sll || w[5:0] == fn_srl || w[5:0] == fn_sra) begin
                w[25:21] = '0;
            end else if (w[5:0] == fn_jr) begin
                w[20:6] = '0;
            end else if (w[5:0] == fn_jalr) begin
                w[20:16] = '0;
                w[10:6] = '0;
            end else begin
                w[10:6] = '0;
            end
        end else if (sel < 20) begin
            w[31:26] = op_regimm;
            w[20:16] = rimm_table[(sel-16)*5 +: 5];
        end else begin
            w[31:26] = op_table[(sel-20)*6 +: 6];
            if (w[31:26] == op_blez || w[31:26] == op_bgtz) w[20:16] = '0;
        end
        return w;
    endfunction

    function automatic fwd_t rand_fwd(input logic [4:0] target);
        fwd_t        f;
        logic [31:0] r;
        r = next_rand();
        f.we = r[0];
        f.is_load = r[1];
        f.waddr = r[2] ? target : {2'b00, r[5:3]};
        f.wdata = next_rand();
        return f;
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        stall = '0;
        fetch = '0;
        wb_write = '0;
        ex_fwd = '0;
        mem_fwd = '0;
    endtask

    task automatic end_test(input string name);
        next_cycle();
        idle_inputs();
        next_cycle();
        tests++;
        $display("test %s done with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic expect_idle();
        compare("id_to_ex.ctrl", '0, id_to_ex.ctrl);
        compare("br.taken", '0, br.taken);
        compare("stall_req", '0, stall_req);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fetch register and register file as the stage should hold them
    always @(posedge clk) begin
        if (rst || (stall.fetch && !stall.decode)) begin
            model_q <= '0;
        end else if (!stall.fetch) begin
            model_q <= fetch;
        end
        if (wb_write.we && wb_write.waddr != 5'd0) begin
            shadow[wb_write.waddr] <= wb_write.wdata;
        end
    end

    always @(negedge clk) begin : output_check
        decode_ctrl_t exp_ctrl;
        br_t          exp_br;
        logic [31:0]  exp_rs;
        logic [31:0]  exp_rt;
        if (check_on) begin
            exp_ctrl = ref_ctrl(model_q.valid, model_q.inst.raw);
            exp_rs = ref_operand(model_q.inst.raw[25:21], ex_fwd, mem_fwd, wb_write);
            exp_rt = ref_operand(model_q.inst.raw[20:16], ex_fwd, mem_fwd, wb_write);
            exp_br = ref_branch(model_q.valid, model_q.pc, model_q.inst.raw, exp_rs, exp_rt);
            compare("id_to_ex.ctrl", exp_ctrl, id_to_ex.ctrl);
            compare("id_to_ex.pc", model_q.pc, id_to_ex.pc);
            compare("id_to_ex.inst", model_q.inst.raw, id_to_ex.inst.raw);
            compare("id_to_ex.rs_value", exp_rs, id_to_ex.rs_value);
            compare("id_to_ex.rt_value", exp_rt, id_to_ex.rt_value);
            compare("br.taken", exp_br.taken, br.taken);
            compare("br.target", exp_br.target, br.target);
            compare("stall_req", ref_stall(model_q.valid, model_q.inst.raw, ex_fwd), stall_req);
        end
    end

    // rs of each word is written in the following drive and comes through the bypass
    task automatic regfile_test();
        for (int k = 0; k < 32; k++) begin
            next_cycle();
            fetch = {1'b1, 32'h400 + 32'(k * 4), 6'h00, 5'(k + 1), 5'(k), 5'd1, 5'd0, fn_addu};
            wb_write = {1'b1, 5'(k), next_rand()};
        end
        for (int k = 0; k < 32; k++) begin
            next_cycle();
            wb_write = '0;
            fetch = {1'b1, 32'h500, 6'h00, 5'(k), 5'(31 - k), 5'd2, 5'd0, fn_or};
        end
        end_test("register writes");
    endtask

    task automatic forward_test();
        logic [4:0] r_now;
        logic [4:0] r_prev;
        fwd_t       tmp;
        r_prev = '0;
        for (int i = 0; i < n_fwd; i++) begin
            next_cycle();
            r_now = 5'(next_rand() & 7);
            fetch = {1'b1, 32'h600, 6'h00, r_now, 5'(next_rand() & 7), 5'd3, 5'd0, fn_addu};
            ex_fwd = rand_fwd(r_prev);
            mem_fwd = rand_fwd(r_prev);
            tmp = rand_fwd(r_prev);
            wb_write = {tmp.we, tmp.waddr, tmp.wdata};
            r_prev = r_now;
        end
        end_test("forwarding");
    endtask

    task automatic decode_test();
        logic [31:0] w;
        for (int i = 0; i < n_dec; i++) begin
            next_cycle();
            w = next_rand();
            if (w[2:0] != 3'd0) w = pick_inst(next_rand() % 35, next_rand());
            fetch = {1'b1, next_rand() & ~32'h3, w};
        end
        for (int k = 0; k < 9; k++) begin
            next_cycle();
            fetch = {1'b1, 32'h700, unknown_words[k*32 +: 32]};
        end
        end_test("decode");
    endtask

    task automatic branch_test();
        logic [31:0] w;
        logic [31:0] prev;
        logic [31:0] a;
        prev = '0;
        for (int i = 0; i < n_br; i++) begin
            next_cycle();
            w = pick_inst(14 + next_rand() % 12, next_rand());
            fetch = {1'b1, next_rand() & ~32'h3, w};
            // operands for the word already in the register
            a = edge_value();
            ex_fwd = {1'b1, 1'b0, prev[25:21], a};
            mem_fwd = {1'b1, 1'b0, prev[20:16], (next_rand() & 1) ? a : edge_value()};
            prev = w;
        end
        end_test("branches");
    endtask

    task automatic load_use_test();
        logic [31:0] w;
        logic [31:0] prev;
        logic [31:0] r;
        prev = '0;
        for (int i = 0; i < n_load; i++) begin
            next_cycle();
            w = pick_inst(next_rand() % 35, next_rand());
            fetch = {1'b1, 32'h800, w};
            r = next_rand();
            ex_fwd.we = r[0] | r[1];
            ex_fwd.is_load = r[2] | r[3];
            case (r[5:4])
                2'd0: ex_fwd.waddr = prev[25:21];
                2'd1: ex_fwd.waddr = prev[20:16];
                2'd2: ex_fwd.waddr = '0;
                default: ex_fwd.waddr = r[10:6];
            endcase
            ex_fwd.wdata = next_rand();
            prev = w;
        end
        end_test("load-use stall");
    endtask

    task automatic stall_test();
        logic [31:0] a;
        a = {op_addiu, 5'd1, 5'd2, 16'h1234};
        next_cycle();
        fetch = {1'b1, 32'h100, a};
        next_cycle();
        fetch = {1'b1, 32'h104, op_lw, 5'd3, 5'd4, 16'h0010};
        stall = 2'b11;
        next_cycle();
        @(negedge clk);
        compare("id_to_ex.inst", a, id_to_ex.inst.raw);
        next_cycle();
        stall = 2'b10;
        next_cycle();
        stall = 2'b00;
        fetch = {1'b1, 32'h108, op_lw, 5'd5, 5'd6, 16'h0020};
        @(negedge clk);
        expect_idle();
        next_cycle();
        ex_fwd = {1'b1, 1'b1, 5'd5, 32'h0};
        next_cycle();
        rst = 1'b1;
        next_cycle();
        @(negedge clk);
        expect_idle();
        next_cycle();
        rst = 1'b0;
        end_test("stall control");
    endtask

    initial begin
        rng_state = 32'h24b67dd8;
        errors = 0;
        checks = 0;
        tests = 0;
        test_base = 0;
        check_on = 1'b0;
        rst = 1'b1;
        idle_inputs();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_on = 1'b1;
        regfile_test();
        forward_test();
        decode_test();
        branch_test();
        load_use_test();
        stall_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #((n_cycles + 100) * 10);
        $display("timeout: the tests did not finish within %0d cycles", n_cycles + 100);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
